// ==== project.f ====
common/merge_pkg.sv
arbiter/encode_one_hot.sv
arbiter/round_robin_arb.sv
src/channel_fifo.sv
src/credit_counter.sv
src/merge_ctrl.sv
src/flit_merge_top.sv
tests/tb_flit_merge.sv

// ==== tests/tb_flit_merge.sv ====
// sources and sink are modeled here; payloads carry channel and sequence, one sink credit per cycle
`timescale 1ns/1ps

module tb_flit_merge;

  import merge_pkg::*;

  // flits per channel in each phase
  localparam int burst_flits = 32;
  localparam int hold_flits = 8;
  localparam int lone_flits = 12;
  localparam int rand_flits = 40;
  localparam int total_flits =
    num_ch * (burst_flits + hold_flits + rand_flits) + lone_flits;
  // run limit in clock cycles
  localparam int cycle_limit = 4 * total_flits + 200;
  // cycles allowed for the last flits and credits to come home
  localparam int drain_limit = 8 * num_ch * fifo_depth;

  logic                 clk_i;
  logic                 rst_i;
  ch_mask_t             in_valid_i;
  data_t [num_ch-1:0]   in_data_i;
  ch_mask_t             in_credit_o;
  logic                 out_valid_o;
  out_flit_t            out_flit_o;
  logic                 out_credit_i;

  // source side bookkeeping
  int sent [num_ch];
  int pulses [num_ch];
  int goal [num_ch];
  // output side bookkeeping
  int rx_seq [num_ch];
  int occ [num_ch];
  int rx_total;
  int ret_total;
  int dcred;
  int last_ch;
  ch_mask_t pend_push;
  logic pend_ret;
  // sink behavior
  logic sink_hold;
  logic sink_eager;
  // error counters and run length
  int mismatch_cnt;
  int fail_cnt;
  int cycle_cnt;
  int unsigned seed_val;
  int drain_wait;

  flit_merge_top DUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_data_i    (in_data_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o),
    .out_credit_i (out_credit_i)
  );

  // 100 ns period
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // payload tag of a flit
  function automatic data_t make_payload(input int c, input int seq);
    return {8'(c), 24'(seq)};
  endfunction

  // next channel after last, searching upward with wrap
  function automatic int next_grant(input ch_mask_t backlog, input int last);
    int c;
    for (int i = 1; i <= num_ch; i++)
    begin
      c = (last + i) % num_ch;
      if (backlog[c])
      begin
        return c;
      end
    end
    return -1;
  endfunction

  // credits a source still holds
  function automatic int src_credit(input int c);
    return fifo_depth - sent[c] + pulses[c];
  endfunction

  // every flit out and every credit home
  function automatic bit all_drained();
    for (int c = 0; c < num_ch; c++)
    begin
      if (rx_seq[c] != sent[c] || pulses[c] != sent[c])
      begin
        return 1'b0;
      end
    end
    return (rx_total == ret_total);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      mismatch_cnt++;
    end
  endtask

  // one source cycle, sending only with credit
  task automatic drive_cycle(input ch_mask_t want);
    @(posedge clk_i);
    #1;
    for (int c = 0; c < num_ch; c++)
    begin
      if (want[c] && src_credit(c) > 0)
      begin
        in_valid_i[c] = 1'b1;
        in_data_i[c]  = make_payload(c, sent[c]);
        sent[c]++;
      end
      else
      begin
        in_valid_i[c] = 1'b0;
      end
    end
  endtask

  // channels still short of their goal
  function automatic ch_mask_t open_mask();
    ch_mask_t m;
    for (int c = 0; c < num_ch; c++)
    begin
      m[c] = (sent[c] < goal[c]);
    end
    return m;
  endfunction

  // traffic until every goal is met, pct is the send chance per cycle
  task automatic send_until(input int pct);
    ch_mask_t want;
    while (open_mask() != '0)
    begin
      want = open_mask();
      for (int c = 0; c < num_ch; c++)
      begin
        want[c] = want[c] && (($urandom % 100) < pct);
      end
      drive_cycle(want);
    end
  endtask

  // sink returns one credit per cycle at most
  always @(posedge clk_i)
  begin
    #1;
    out_credit_i = 1'b0;
    if (!sink_hold && rx_total > ret_total && (sink_eager || ($urandom % 2) == 0))
    begin
      out_credit_i = 1'b1;
      ret_total++;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk_i)
  begin : monitor
    ch_mask_t backlog;
    ch_mask_t exp_credit;
    int exp_ch;
    int ch;
    if (!rst_i)
    begin
      // fifo state the arbiter saw before this edge
      for (int c = 0; c < num_ch; c++)
      begin
        backlog[c] = (occ[c] > 0);
      end
      exp_ch = next_grant(backlog, last_ch);
      check_value("out_valid_o", (backlog != '0) && (dcred > 0), out_valid_o);
      exp_credit = '0;
      if (out_valid_o === 1'b1)
      begin
        ch = int'(out_flit_o.ch);
        check_value("out_flit_o.ch", exp_ch, ch);
        exp_credit[ch] = 1'b1;
        if (rx_seq[ch] >= sent[ch])
        begin
          $display("flit from channel %0d at %0t with nothing pending", ch, $time);
          fail_cnt++;
        end
        else
        begin
          check_value("out_flit_o.data", make_payload(ch, rx_seq[ch]), out_flit_o.data);
          rx_seq[ch]++;
          occ[ch]--;
        end
        last_ch = ch;
        dcred--;
        rx_total++;
      end
      // credit goes back with the pop
      check_value("in_credit_o", exp_credit, in_credit_o);
      for (int c = 0; c < num_ch; c++)
      begin
        if (in_credit_o[c] === 1'b1)
        begin
          pulses[c]++;
        end
        if (pulses[c] > sent[c])
        begin
          $display("channel %0d credited more slots than it sent at %0t", c, $time);
          fail_cnt++;
        end
        occ[c] += pend_push[c];
      end
      dcred += pend_ret;
      if (dcred > out_credits)
      begin
        $display("sink returned a credit it did not hold at %0t", $time);
        fail_cnt++;
      end
      // applied at the next edge
      pend_push = in_valid_i;
      pend_ret  = out_credit_i;
    end
  end

  // run limit
  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles with flits or credits still outstanding", cycle_cnt);
      $display("checks: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    seed_val = $urandom(32'h768d13ab);
    for (int c = 0; c < num_ch; c++)
    begin
      sent[c]   = 0;
      pulses[c] = 0;
      goal[c]   = 0;
      rx_seq[c] = 0;
      occ[c]    = 0;
    end
    rx_total     = 0;
    ret_total    = 0;
    dcred        = out_credits;
    // channel 0 first after reset
    last_ch      = num_ch - 1;
    pend_push    = '0;
    pend_ret     = 1'b0;
    sink_hold    = 1'b0;
    sink_eager   = 1'b1;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    cycle_cnt    = 0;
    drain_wait   = 0;
    in_valid_i   = '0;
    in_data_i    = '0;
    out_credit_i = 1'b0;
    rst_i        = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // quiet link before any input
    repeat (10) drive_cycle('0);

    // all channels backlogged, credits back at once
    for (int c = 0; c < num_ch; c++)
    begin
      goal[c] += burst_flits;
    end
    send_until(100);

    // sink withholds credits, then lets go
    for (int c = 0; c < num_ch; c++)
    begin
      goal[c] += hold_flits;
    end
    // sink mode changes away from the sink's own edge
    @(negedge clk_i);
    sink_hold = 1'b1;
    repeat (24) drive_cycle(open_mask());
    // backlog uses up every downstream credit and no more
    if (rx_total - ret_total != out_credits)
    begin
      $display("%0d flits unreturned while the sink held its credits, expected %0d",
               rx_total - ret_total, out_credits);
      fail_cnt++;
    end
    @(negedge clk_i);
    sink_hold = 1'b0;
    send_until(100);

    // lone channel, then sparse random traffic
    goal[2] += lone_flits;
    send_until(100);
    @(negedge clk_i);
    sink_eager = 1'b0;
    for (int c = 0; c < num_ch; c++)
    begin
      goal[c] += rand_flits;
    end
    send_until(25);

    // drain
    drive_cycle('0);
    while (!all_drained() && drain_wait < drain_limit)
    begin
      @(posedge clk_i);
      drain_wait++;
    end
    repeat (4) @(posedge clk_i);
    for (int c = 0; c < num_ch; c++)
    begin
      if (rx_seq[c] != sent[c])
      begin
        $display("channel %0d has %0d flits left over", c, sent[c] - rx_seq[c]);
        fail_cnt++;
      end
      if (src_credit(c) != fifo_depth)
      begin
        $display("channel %0d ends with %0d credits", c, src_credit(c));
        fail_cnt++;
      end
    end

    $display("checks: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/flit_merge_top.sv ====
// each source must hold a credit per flit, starting with fifo_depth; sink starts with out_credits
`timescale 1ns/1ps

module flit_merge_top (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  merge_pkg::ch_mask_t                      in_valid_i,
  input  merge_pkg::data_t [merge_pkg::num_ch-1:0] in_data_i,
  output merge_pkg::ch_mask_t                      in_credit_o,
  output logic                                     out_valid_o,
  output merge_pkg::out_flit_t                     out_flit_o,
  input  logic                                     out_credit_i
);

  import merge_pkg::*;

  // fifo status and data toward the control side
  ch_mask_t               not_empty;
  data_t [num_ch-1:0]     head;
  ch_mask_t               pop;
  // arbitration
  ch_mask_t               grant;
  ch_idx_t                grant_idx;
  logic                   grant_any;
  logic                   advance;
  // downstream credit
  logic                   send;
  logic                   has_credit;

  // one fifo per source channel
  for (genvar c = 0; c < num_ch; c++)
  begin : g_ch
    channel_fifo u_fifo (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (in_valid_i[c]),
      .data_i      (in_data_i[c]),
      .pop_i       (pop[c]),
      .not_empty_o (not_empty[c]),
      .head_o      (head[c])
    );
  end

  // waiting channels compete
  round_robin_arb u_arb (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (not_empty),
    .advance_i (advance),
    .grant_o   (grant)
  );

  // one-hot grant to channel index
  encode_one_hot #(
    .width_p (num_ch)
  ) u_enc (
    .i      (grant),
    .addr_o (grant_idx),
    .v_o    (grant_any)
  );

  // slots free on the output link
  credit_counter u_credit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .send_i       (send),
    .credit_ret_i (out_credit_i),
    .has_credit_o (has_credit)
  );

  merge_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .grant_any_i  (grant_any),
    .grant_idx_i  (grant_idx),
    .head_i       (head),
    .has_credit_i (has_credit),
    .pop_o        (pop),
    .advance_o    (advance),
    .send_o       (send),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o)
  );

endmodule

// ==== src/merge_ctrl.sv ====
// pops at most one flit per cycle; grant_idx_i is only meaningful while grant_any_i is high
`timescale 1ns/1ps

module merge_ctrl (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       grant_any_i,
  input  merge_pkg::ch_idx_t                         grant_idx_i,
  input  merge_pkg::data_t [merge_pkg::num_ch-1:0]   head_i,
  input  logic                                       has_credit_i,
  output merge_pkg::ch_mask_t                        pop_o,
  output logic                                       advance_o,
  output logic                                       send_o,
  output merge_pkg::ch_mask_t                        in_credit_o,
  output logic                                       out_valid_o,
  output merge_pkg::out_flit_t                       out_flit_o
);

  import merge_pkg::*;

  // a flit moves this cycle
  logic fire;

  // registered output side
  logic      out_valid_q;
  out_flit_t out_flit_q;
  // registered credit return toward the sources
  ch_mask_t  in_credit_q;

  // granted channel with a downstream slot free
  assign fire = grant_any_i & has_credit_i;

  // pop only the granted fifo
  assign pop_o = fire ? (ch_mask_t'(1) << grant_idx_i) : '0;

  // arbiter rotates and the link credit drops on the same edge
  assign advance_o = fire;
  assign send_o    = fire;

  // control state
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      out_valid_q <= 1'b0;
      in_credit_q <= '0;
    end
    else
    begin
      // one cycle per flit
      out_valid_q <= fire;
      // freed slot goes back to its source with the pop
      in_credit_q <= pop_o;
    end
  end

  // output flit register
  // held between sends, qualified by out_valid_o
  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      out_flit_q.ch   <= grant_idx_i;
      out_flit_q.data <= head_i[grant_idx_i];
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;
  assign in_credit_o = in_credit_q;

endmodule

// ==== src/credit_counter.sv ====
// sink must never return more credits than it was sent; the count does not saturate
`timescale 1ns/1ps

module credit_counter (
  input  logic clk_i,
  input  logic rst_i,
  input  logic send_i,
  input  logic credit_ret_i,
  output logic has_credit_o
);

  import merge_pkg::*;

  // free slots downstream
  credit_cnt_t cnt_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      // link starts with every slot free
      cnt_q <= credit_cnt_t'(out_credits);
    end
    else
    begin
      case ({send_i, credit_ret_i})
        // flit sent, slot taken
        2'b10:   cnt_q <= cnt_q - credit_cnt_t'(1);
        // slot freed by the sink
        2'b01:   cnt_q <= cnt_q + credit_cnt_t'(1);
        // both or neither cancel out
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // send allowed this cycle
  assign has_credit_o = (cnt_q != '0);

endmodule

// ==== src/channel_fifo.sv ====
// no full flag; the source credit protocol must keep pushes within fifo_depth
`timescale 1ns/1ps

module channel_fifo (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            push_i,
  input  merge_pkg::data_t data_i,
  input  logic            pop_i,
  output logic            not_empty_o,
  output merge_pkg::data_t head_o
);

  import merge_pkg::*;

  // flit storage
  data_t mem [fifo_depth];

  // read and write slots
  fifo_ptr_t rd_ptr_q;
  fifo_ptr_t wr_ptr_q;
  // entries held
  fifo_cnt_t count_q;

  // step a pointer, wrapping for any depth
  function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t p);
    if (p == fifo_ptr_t'(fifo_depth - 1))
    begin
      return '0;
    end
    return p + fifo_ptr_t'(1);
  endfunction

  // storage write
  // payload only, so no reset
  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i)
      begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop keeps the count
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + fifo_cnt_t'(1);
        2'b01:   count_q <= count_q - fifo_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // head is visible the cycle after its push
  assign not_empty_o = (count_q != '0);
  // read port is combinational
  assign head_o      = mem[rd_ptr_q];

endmodule

// ==== arbiter/round_robin_arb.sv ====
// grant is one-hot or zero and combinational from req_i; priority moves only on advance_i
`timescale 1ns/1ps

module round_robin_arb (
  input  logic               clk_i,
  input  logic               rst_i,
  input  merge_pkg::ch_mask_t req_i,
  input  logic               advance_i,
  output merge_pkg::ch_mask_t grant_o
);

  import merge_pkg::*;

  // channel holding the highest priority
  ch_idx_t ptr_q;
  // pointer after the current grant
  ch_idx_t ptr_nxt;

  // requests at or above the pointer
  ch_mask_t hi_mask;
  ch_mask_t masked_req;
  // lowest set bit of each request set
  ch_mask_t masked_pick;
  ch_mask_t plain_pick;

  // clear the bits below the pointer
  assign hi_mask    = ~((ch_mask_t'(1) << ptr_q) - ch_mask_t'(1));
  assign masked_req = req_i & hi_mask;

  // x & -x isolates the lowest set bit
  assign masked_pick = masked_req & (~masked_req + ch_mask_t'(1));
  assign plain_pick  = req_i & (~req_i + ch_mask_t'(1));

  // nothing at or above the pointer, so wrap to the bottom
  assign grant_o = (masked_req != '0) ? masked_pick : plain_pick;

  // channel after the granted one, wrapping at num_ch
  always_comb
  begin
    ptr_nxt = ptr_q;
    for (int c = 0; c < num_ch; c++)
    begin
      if (grant_o[c])
      begin
        ptr_nxt = (c == num_ch - 1) ? ch_idx_t'(0) : ch_idx_t'(c + 1);
      end
    end
  end

  // channel 0 first after reset
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ptr_q <= '0;
    end
    else if (advance_i)
    begin
      // rotate past the accepted channel
      ptr_q <= ptr_nxt;
    end
  end

endmodule

// ==== arbiter/encode_one_hot.sv ====
// input must be one-hot or zero; several set bits give an OR of their indices
`timescale 1ns/1ps

module encode_one_hot #(
  parameter int width_p = 4
) (
  input  logic [width_p-1:0]                            i,
  output logic [((width_p > 1) ? $clog2(width_p) : 1)-1:0] addr_o,
  output logic                                          v_o
);

  // a single input still needs one address bit
  localparam int addr_w_lp = (width_p > 1) ? $clog2(width_p) : 1;
  // tree depth
  localparam int levels_lp = $clog2(width_p);
  // width rounded up to a power of two
  localparam int aligned_lp = 1 << levels_lp;

  // per level, results sit at the first bit of each segment slot
  // the other bits of a level are never used
  wire [levels_lp:0][aligned_lp-1:0] addr;
  wire [levels_lp:0][aligned_lp-1:0] v;

  // leaves
  // zero padding goes at the top for odd widths
  assign v[0]    = aligned_lp'(i);
  assign addr[0] = '0;

  for (genvar lvl = 1; lvl <= levels_lp; lvl++)
  begin : g_level
    // segments merged at this level
    localparam int seg_cnt_lp = 2 ** (levels_lp - lvl);
    // bits of the padded input spanned by one segment
    localparam int slot_lp = aligned_lp / seg_cnt_lp;

    for (genvar s = 0; s < seg_cnt_lp; s++)
    begin : g_seg
      // lower and upper halves of this segment
      wire lo_v;
      wire hi_v;

      assign lo_v = v[lvl-1][s*slot_lp];
      assign hi_v = v[lvl-1][s*slot_lp + slot_lp/2];

      // any bit set within the segment
      assign v[lvl][s*slot_lp] = lo_v | hi_v;

      if (lvl == 1)
      begin : g_leaf
        // pair of inputs, upper one sets the bit
        assign addr[lvl][s*slot_lp] = hi_v;
      end
      else
      begin : g_node
        // new msb from the upper half
        // lower bits from whichever half holds the set bit
        assign addr[lvl][s*slot_lp +: lvl] =
          {hi_v,
           addr[lvl-1][s*slot_lp +: lvl-1] |
           addr[lvl-1][s*slot_lp + slot_lp/2 +: lvl-1]};
      end
    end
  end

  // root of the tree
  assign addr_o = addr[levels_lp][addr_w_lp-1:0];
  assign v_o    = v[levels_lp][0];

endmodule

// ==== common/merge_pkg.sv ====
// shared widths and types for the merger; fifo_depth and out_credits must stay >= 1
package merge_pkg;

  // number of source channels feeding the merger
  localparam int num_ch = 4;

  // flit payload width
  localparam int data_w = 32;

  // slots per channel fifo
  // also the credits each source starts with
  localparam int fifo_depth = 4;

  // credits held toward the downstream link after reset
  localparam int out_credits = 4;

  // derived widths
  localparam int ch_idx_w = (num_ch > 1) ? $clog2(num_ch) : 1;
  localparam int fifo_ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  // counts run from zero up to and including the maximum
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);
  localparam int credit_cnt_w = $clog2(out_credits + 1);

  // channel index
  typedef logic [ch_idx_w-1:0] ch_idx_t;

  // one bit per channel
  // requests, grants, valids, credit returns
  typedef logic [num_ch-1:0] ch_mask_t;

  // flit payload
  typedef logic [data_w-1:0] data_t;

  // downstream credit count, zero to out_credits
  typedef logic [credit_cnt_w-1:0] credit_cnt_t;

  // fifo slot pointer
  typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;

  // fifo occupancy, zero to fifo_depth
  typedef logic [fifo_cnt_w-1:0] fifo_cnt_t;

  // flit on the output link
  // channel on top, payload below
  typedef struct packed {
    ch_idx_t ch;
    data_t   data;
  } out_flit_t;

endpackage
